// File: source/read_engine_config.svh
`ifndef READ_ENGINE_CONFIG_SVH
`define READ_ENGINE_CONFIG_SVH

`default_nettype none

// bus and counter widths
`define RE_ADDR_WIDTH  64
`define RE_SIZE_WIDTH  32
`define RE_CHUNK_WIDTH 11

// memory geometry for 4-byte elements
`define RE_CACHELINE_BYTES 128
`define RE_ELEMS_PER_LINE  32
`define RE_PAGE_BYTES      4096
`define RE_ELEMS_PER_PAGE  1024

// read commands allowed in flight per burst
`define RE_MAX_BURST 16

// fixed command tag of this engine
`define RE_TAG_WIDTH 8
`define RE_TAG       `RE_TAG_WIDTH'('h2c)

`default_nettype wire

`endif

// File: source/command_pkg.sv
`default_nettype none

package command_pkg;

	// memory command opcodes, CAPI encodings
	typedef enum logic [12:0] {
		READ_CL_S  = 13'h0a50,
		READ_CL_NA = 13'h0a00,
		READ_PNA   = 13'h0e00,
		TOUCH_I    = 13'h0240
	} opcode_t;

endpackage

`default_nettype wire

// File: source/control_pkg.sv
`default_nettype none

package control_pkg;

	// when data-out almost-full holds back reads
	typedef enum logic [1:0] {
		GATE_ALWAYS       = 2'd0,
		GATE_ON_DATA_FULL = 2'd1,
		GATE_BYPASS       = 2'd2
	} gate_mode_t;

	typedef struct packed {
		logic       shared_reads;
		gate_mode_t gate_mode;
	} job_cfg_t;

	// job sequencer states
	typedef enum logic [3:0] {
		S_IDLE,
		S_PF_START,
		S_PF_REQ,
		S_PF_WAIT,
		S_RD_START,
		S_RD_REQ,
		S_RD_WAIT,
		S_RD_NEXT,
		S_FINAL
	} seq_state_t;

endpackage

`default_nettype wire

// File: source/engine_ifs.sv
`include "read_engine_config.svh"
`timescale 1ns/1ns
`default_nettype none

// job descriptor, stable from capture until the next job
interface job_if
	import control_pkg::*;
();
	logic [`RE_ADDR_WIDTH-1:0] base_address;
	logic [`RE_SIZE_WIDTH-1:0] element_count;
	job_cfg_t                  cfg;
	logic                      prefetch_on;

	modport source (output base_address, output element_count, output cfg, output prefetch_on);
	modport sink   (input base_address, input element_count, input cfg, input prefetch_on);
endinterface

// control and status between sequencer, issuers and tracker
interface stream_if;
	logic rd_go;
	logic pf_go;
	logic load;
	logic rd_issued;
	logic pf_issued;
	logic rd_burst_end;
	logic rd_left;
	logic pf_left;
	logic rd_drained;
	logic pf_drained;

	modport sequencer (
		output rd_go, pf_go, load,
		input  rd_burst_end, rd_left, pf_left, rd_drained, pf_drained
	);
	modport read_issuer     (input rd_go, load, rd_drained, output rd_issued, rd_burst_end, rd_left);
	modport prefetch_issuer (input pf_go, load, output pf_issued, pf_left);
	modport tracker         (input rd_issued, pf_issued, output rd_drained, pf_drained);
endinterface

`default_nettype wire

// File: source/job_intake.sv
`include "read_engine_config.svh"
`timescale 1ns/1ns
`default_nettype none

module job_intake
	import control_pkg::*;
(
	input  logic                      clock,
	input  logic                      rstn,
	input  logic                      enable,
	input  logic                      prefetch_enable,
	input  logic [`RE_ADDR_WIDTH-1:0] job_base,
	input  logic [`RE_SIZE_WIDTH-1:0] job_size,
	input  job_cfg_t                  job_cfg,
	input  logic                      load,
	output logic                      enable_q,
	job_if.source                     job
);

	logic prefetch_enable_q;

	////////////////////////////////////////////////////////////////////////////
	// enable levels
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			enable_q          <= 1'b0;
			prefetch_enable_q <= 1'b0;
		end else begin
			enable_q          <= enable;
			prefetch_enable_q <= prefetch_enable;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// job capture
	////////////////////////////////////////////////////////////////////////////

	// held until the next accepted job
	always_ff @(posedge clock) begin
		if (load) begin
			job.base_address  <= job_base;
			job.element_count <= job_size;
			job.cfg           <= job_cfg;
			job.prefetch_on   <= prefetch_enable_q;
		end
	end

	// an empty job would never raise done
	a_job_not_empty: assert property (
		@(posedge clock) disable iff (!rstn) load |=> (job.element_count != '0)
	) else $error("job_intake: zero element count captured");

endmodule

`default_nettype wire

// File: source/stream_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

module stream_sequencer
	import control_pkg::*;
(
	input  logic        clock,
	input  logic        rstn,
	input  logic        enable_q,
	input  logic        job_valid,
	stream_if.sequencer stream,
	output logic        job_done,
	output logic        load
);

	seq_state_t state;
	seq_state_t state_next;

	////////////////////////////////////////////////////////////////////////////
	// job state machine
	////////////////////////////////////////////////////////////////////////////

	// enable low freezes the sequence
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state <= S_IDLE;
		end else if (enable_q) begin
			state <= state_next;
		end
	end

	always_comb begin
		state_next = state;
		case (state)
			S_IDLE: begin
				if (job_valid)
					state_next = S_PF_START;
			end
			// issuers pick up the job here
			S_PF_START: state_next = S_PF_REQ;
			S_PF_REQ: begin
				if (!stream.pf_left)
					state_next = S_PF_WAIT;
			end
			S_PF_WAIT: begin
				if (stream.pf_drained)
					state_next = S_RD_START;
			end
			S_RD_START: state_next = S_RD_REQ;
			S_RD_REQ: begin
				if (stream.rd_burst_end || !stream.rd_left)
					state_next = S_RD_WAIT;
			end
			// whole burst must come back first
			S_RD_WAIT: begin
				if (stream.rd_drained)
					state_next = S_RD_NEXT;
			end
			S_RD_NEXT: state_next = stream.rd_left ? S_RD_START : S_FINAL;
			S_FINAL:   state_next = S_FINAL;
			default:   state_next = S_IDLE;
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// outputs
	////////////////////////////////////////////////////////////////////////////

	assign load         = (state == S_IDLE) && job_valid && enable_q;
	assign stream.load  = load;
	assign stream.pf_go = (state == S_PF_REQ) && enable_q;
	assign stream.rd_go = (state == S_RD_REQ) && enable_q;
	assign job_done     = (state == S_FINAL);

	a_state_known: assert property (
		@(posedge clock) disable iff (!rstn) !$isunknown(state)
	) else $error("stream_sequencer: state unknown");

	// touch pass and read bursts never overlap
	a_one_pass: assert property (
		@(posedge clock) disable iff (!rstn) stream.rd_go |-> !stream.pf_left
	) else $error("stream_sequencer: reads started with touches left");

endmodule

`default_nettype wire

// File: source/read_command_issuer.sv
`include "read_engine_config.svh"
`timescale 1ns/1ns
`default_nettype none

module read_command_issuer
	import command_pkg::*;
	import control_pkg::*;
(
	input  logic                       clock,
	input  logic                       rstn,
	job_if.sink                        job,
	stream_if.read_issuer              stream,
	input  logic                       read_cmd_full,
	input  logic                       data_out_full,
	output logic                       read_cmd_valid,
	output opcode_t                    read_cmd_opcode,
	output logic [`RE_ADDR_WIDTH-1:0]  read_cmd_address,
	output logic [`RE_CHUNK_WIDTH-1:0] read_cmd_elems
);

	localparam int BURST_WIDTH = $clog2(`RE_MAX_BURST + 1);
	localparam logic [`RE_CHUNK_WIDTH-1:0] LINE_ELEMS = `RE_CHUNK_WIDTH'(`RE_ELEMS_PER_LINE);
	localparam logic [`RE_ADDR_WIDTH-1:0]  LINE_BYTES = `RE_ADDR_WIDTH'(`RE_CACHELINE_BYTES);

	logic                       load_q;
	logic [`RE_SIZE_WIDTH-1:0]  remaining;
	logic [`RE_ADDR_WIDTH-1:0]  offset;
	logic [BURST_WIDTH-1:0]     burst_count;
	logic                       last_chunk;
	logic [`RE_CHUNK_WIDTH-1:0] chunk;
	logic                       data_ready;
	logic                       fire;

	// at most one cacheline per command
	assign last_chunk = remaining <= `RE_SIZE_WIDTH'(`RE_ELEMS_PER_LINE);
	assign chunk      = last_chunk ? remaining[`RE_CHUNK_WIDTH-1:0] : LINE_ELEMS;

	// only the data-full gating mode looks at the downstream buffer
	assign data_ready = !((job.cfg.gate_mode == GATE_ON_DATA_FULL) && data_out_full);

	assign stream.rd_left      = (remaining != '0);
	assign stream.rd_burst_end = (burst_count == BURST_WIDTH'(`RE_MAX_BURST));

	assign fire = stream.rd_go && stream.rd_left && !stream.rd_burst_end &&
		!read_cmd_full && data_ready;
	assign stream.rd_issued = fire;

	////////////////////////////////////////////////////////////////////////////
	// position in the job
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			load_q         <= 1'b0;
			remaining      <= '0;
			offset         <= '0;
			burst_count    <= '0;
			read_cmd_valid <= 1'b0;
		end else begin
			load_q         <= stream.load;
			read_cmd_valid <= fire;
			// job fields are valid one cycle after load
			if (load_q) begin
				remaining <= job.element_count;
				offset    <= '0;
			end else if (fire) begin
				remaining <= remaining - `RE_SIZE_WIDTH'(chunk);
				offset    <= offset + LINE_BYTES;
			end
			// new burst only once the last one is drained
			if (fire)
				burst_count <= burst_count + 1'b1;
			else if (!stream.rd_go && stream.rd_drained)
				burst_count <= '0;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// command payload
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (fire) begin
			read_cmd_address <= job.base_address + offset;
			read_cmd_elems   <= chunk;
			if (job.cfg.shared_reads)
				read_cmd_opcode <= READ_CL_S;
			else if (last_chunk)
				read_cmd_opcode <= READ_PNA;
			else
				read_cmd_opcode <= READ_CL_NA;
		end
	end

endmodule

`default_nettype wire

// File: source/prefetch_command_issuer.sv
`include "read_engine_config.svh"
`timescale 1ns/1ns
`default_nettype none

module prefetch_command_issuer (
	input  logic                      clock,
	input  logic                      rstn,
	job_if.sink                       job,
	stream_if.prefetch_issuer         stream,
	input  logic                      prefetch_cmd_full,
	output logic                      prefetch_cmd_valid,
	output logic [`RE_ADDR_WIDTH-1:0] prefetch_cmd_address
);

	localparam logic [`RE_ADDR_WIDTH-1:0] PAGE_BYTES = `RE_ADDR_WIDTH'(`RE_PAGE_BYTES);
	localparam logic [`RE_ADDR_WIDTH-1:0] PAGE_MASK  = ~(PAGE_BYTES - 1'b1);
	localparam logic [`RE_SIZE_WIDTH-1:0] PAGE_ELEMS = `RE_SIZE_WIDTH'(`RE_ELEMS_PER_PAGE);

	logic                      load_q;
	logic [`RE_SIZE_WIDTH-1:0] remaining;
	logic [`RE_ADDR_WIDTH-1:0] page_base;
	logic [`RE_ADDR_WIDTH-1:0] offset;
	logic                      fire;

	assign stream.pf_left   = (remaining != '0);
	assign fire             = stream.pf_go && stream.pf_left && !prefetch_cmd_full;
	assign stream.pf_issued = fire;

	// one touch per page worth of elements
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			load_q             <= 1'b0;
			remaining          <= '0;
			offset             <= '0;
			prefetch_cmd_valid <= 1'b0;
		end else begin
			load_q             <= stream.load;
			prefetch_cmd_valid <= fire;
			if (load_q) begin
				// nothing left means the pass is skipped
				remaining <= job.prefetch_on ? job.element_count : '0;
				offset    <= '0;
			end else if (fire) begin
				remaining <= (remaining > PAGE_ELEMS) ? remaining - PAGE_ELEMS : '0;
				offset    <= offset + PAGE_BYTES;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (load_q)
			page_base <= job.base_address & PAGE_MASK;
		if (fire)
			prefetch_cmd_address <= page_base + offset;
	end

endmodule

`default_nettype wire

// File: source/response_tracker.sv
`include "read_engine_config.svh"
`timescale 1ns/1ns
`default_nettype none

module response_tracker (
	input  logic                       clock,
	input  logic                       rstn,
	stream_if.tracker                  stream,
	input  logic                       read_resp_valid,
	input  logic [`RE_CHUNK_WIDTH-1:0] read_resp_elems,
	input  logic                       prefetch_resp_valid,
	output logic [`RE_SIZE_WIDTH-1:0]  elements_done
);

	logic [`RE_SIZE_WIDTH-1:0] rd_outstanding;
	logic [`RE_SIZE_WIDTH-1:0] pf_outstanding;

	// up on issue, down on response
	function automatic logic [`RE_SIZE_WIDTH-1:0] step(
		input logic [`RE_SIZE_WIDTH-1:0] count,
		input logic                      up,
		input logic                      down
	);
		case ({up, down})
			2'b10:   return count + 1'b1;
			2'b01:   return count - 1'b1;
			default: return count;
		endcase
	endfunction

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			rd_outstanding <= '0;
			pf_outstanding <= '0;
			elements_done  <= '0;
		end else begin
			rd_outstanding <= step(rd_outstanding, stream.rd_issued, read_resp_valid);
			pf_outstanding <= step(pf_outstanding, stream.pf_issued, prefetch_resp_valid);
			if (read_resp_valid)
				elements_done <= elements_done + `RE_SIZE_WIDTH'(read_resp_elems);
		end
	end

	assign stream.rd_drained = (rd_outstanding == '0);
	assign stream.pf_drained = (pf_outstanding == '0);

	a_no_stray_read: assert property (
		@(posedge clock) disable iff (!rstn) read_resp_valid |-> (rd_outstanding != '0)
	) else $error("response_tracker: read response with nothing outstanding");

	a_no_stray_touch: assert property (
		@(posedge clock) disable iff (!rstn) prefetch_resp_valid |-> (pf_outstanding != '0)
	) else $error("response_tracker: touch response with nothing outstanding");

	// burst limit from the read issuer holds end to end
	a_burst_limit: assert property (
		@(posedge clock) disable iff (!rstn) rd_outstanding <= `RE_SIZE_WIDTH'(`RE_MAX_BURST)
	) else $error("response_tracker: too many reads outstanding");

endmodule

`default_nettype wire

// File: source/read_engine_top.sv
`include "read_engine_config.svh"
`timescale 1ns/1ns
`default_nettype none

module read_engine_top
	import command_pkg::*;
	import control_pkg::*;
(
	input  logic                       clock,
	input  logic                       rstn,
	input  logic                       enable,
	input  logic                       prefetch_enable,
	input  logic                       job_valid,
	input  logic [`RE_ADDR_WIDTH-1:0]  job_base,
	input  logic [`RE_SIZE_WIDTH-1:0]  job_size,
	input  job_cfg_t                   job_cfg,
	// buffer back-pressure
	input  logic                       read_cmd_full,
	input  logic                       prefetch_cmd_full,
	input  logic                       data_out_full,
	// responses
	input  logic                       read_resp_valid,
	input  logic [`RE_CHUNK_WIDTH-1:0] read_resp_elems,
	input  logic                       prefetch_resp_valid,
	// commands
	output logic                       read_cmd_valid,
	output opcode_t                    read_cmd_opcode,
	output logic [`RE_ADDR_WIDTH-1:0]  read_cmd_address,
	output logic [`RE_CHUNK_WIDTH-1:0] read_cmd_elems,
	output logic                       prefetch_cmd_valid,
	output logic [`RE_ADDR_WIDTH-1:0]  prefetch_cmd_address,
	output logic [`RE_TAG_WIDTH-1:0]   command_tag,
	// status
	output logic [`RE_SIZE_WIDTH-1:0]  elements_done,
	output logic                       job_done
);

	logic enable_q;
	logic load;

	job_if    job_bus ();
	stream_if stream ();

	// every command of this engine carries the same tag
	assign command_tag = `RE_TAG;

	job_intake u_intake (
		.clock           (clock),
		.rstn            (rstn),
		.enable          (enable),
		.prefetch_enable (prefetch_enable),
		.job_base        (job_base),
		.job_size        (job_size),
		.job_cfg         (job_cfg),
		.load            (load),
		.enable_q        (enable_q),
		.job             (job_bus.source)
	);

	stream_sequencer u_sequencer (
		.clock     (clock),
		.rstn      (rstn),
		.enable_q  (enable_q),
		.job_valid (job_valid),
		.stream    (stream.sequencer),
		.job_done  (job_done),
		.load      (load)
	);

	read_command_issuer u_read_issuer (
		.clock            (clock),
		.rstn             (rstn),
		.job              (job_bus.sink),
		.stream           (stream.read_issuer),
		.read_cmd_full    (read_cmd_full),
		.data_out_full    (data_out_full),
		.read_cmd_valid   (read_cmd_valid),
		.read_cmd_opcode  (read_cmd_opcode),
		.read_cmd_address (read_cmd_address),
		.read_cmd_elems   (read_cmd_elems)
	);

	prefetch_command_issuer u_prefetch_issuer (
		.clock                (clock),
		.rstn                 (rstn),
		.job                  (job_bus.sink),
		.stream               (stream.prefetch_issuer),
		.prefetch_cmd_full    (prefetch_cmd_full),
		.prefetch_cmd_valid   (prefetch_cmd_valid),
		.prefetch_cmd_address (prefetch_cmd_address)
	);

	response_tracker u_tracker (
		.clock               (clock),
		.rstn                (rstn),
		.stream              (stream.tracker),
		.read_resp_valid     (read_resp_valid),
		.read_resp_elems     (read_resp_elems),
		.prefetch_resp_valid (prefetch_resp_valid),
		.elements_done       (elements_done)
	);

endmodule

`default_nettype wire

// File: sim/tb_read_engine.sv
`include "read_engine_config.svh"
`timescale 1ns/1ns
`default_nettype none

module tb_read_engine
	import command_pkg::*;
	import control_pkg::*;
();

	localparam int NUM_JOBS = 5;

	logic                       clock;
	logic                       rstn;
	logic                       enable;
	logic                       prefetch_enable;
	logic                       job_valid;
	logic [`RE_ADDR_WIDTH-1:0]  job_base;
	logic [`RE_SIZE_WIDTH-1:0]  job_size;
	job_cfg_t                   job_cfg;
	logic                       read_cmd_full;
	logic                       prefetch_cmd_full;
	logic                       data_out_full;
	logic                       read_resp_valid;
	logic [`RE_CHUNK_WIDTH-1:0] read_resp_elems;
	logic                       prefetch_resp_valid;
	logic                       read_cmd_valid;
	opcode_t                    read_cmd_opcode;
	logic [`RE_ADDR_WIDTH-1:0]  read_cmd_address;
	logic [`RE_CHUNK_WIDTH-1:0] read_cmd_elems;
	logic                       prefetch_cmd_valid;
	logic [`RE_ADDR_WIDTH-1:0]  prefetch_cmd_address;
	logic [`RE_TAG_WIDTH-1:0]   command_tag;
	logic [`RE_SIZE_WIDTH-1:0]  elements_done;
	logic                       job_done;

	// job table
	string                     name_list [NUM_JOBS];
	logic [`RE_ADDR_WIDTH-1:0] base_list [NUM_JOBS];
	logic [`RE_SIZE_WIDTH-1:0] size_list [NUM_JOBS];
	job_cfg_t                  cfg_list [NUM_JOBS];
	bit                        pf_list [NUM_JOBS];
	bit                        pressure_list [NUM_JOBS];
	bit                        pause_list [NUM_JOBS];

	int          seed = 12;
	int          error_count = 0;
	int          failed_tests = 0;
	int          cycle_count = 0;
	int          timeout_limit = 0;
	bit          pressure = 0;
	int unsigned rd_index;
	int unsigned pf_index;
	int unsigned rd_elem_sum;
	int          rd_out_count;
	int          pf_out_count;
	int          rd_wait = 0;
	int          pf_wait = 0;
	logic [`RE_CHUNK_WIDTH-1:0] rd_queue [$];
	bit                         pf_queue [$];

	logic [`RE_SIZE_WIDTH-1:0] exp_rd_left;
	logic [`RE_SIZE_WIDTH-1:0] exp_rd_elems;
	logic [`RE_ADDR_WIDTH-1:0] exp_rd_address;
	logic [`RE_ADDR_WIDTH-1:0] exp_pf_address;
	int unsigned               exp_pf_total;
	opcode_t                   exp_rd_opcode;

	read_engine_top UUT (.*);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	task automatic report_error(input string msg);
		error_count++;
		$display("[ERROR] %0t: %s", $time, msg);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// expected command stream
	////////////////////////////////////////////////////////////////////////////

	assign exp_rd_left    = job_size - rd_index * `RE_ELEMS_PER_LINE;
	assign exp_rd_elems   = (exp_rd_left < `RE_ELEMS_PER_LINE) ? exp_rd_left : `RE_ELEMS_PER_LINE;
	assign exp_rd_address = job_base + 64'(rd_index) * `RE_CACHELINE_BYTES;
	assign exp_pf_address = (job_base & ~64'(`RE_PAGE_BYTES - 1)) +
		64'(pf_index) * `RE_PAGE_BYTES;
	assign exp_pf_total   = prefetch_enable ?
		(job_size + `RE_ELEMS_PER_PAGE - 1) / `RE_ELEMS_PER_PAGE : 0;

	always_comb begin
		if (job_cfg.shared_reads)
			exp_rd_opcode = READ_CL_S;
		else if (exp_rd_left <= `RE_ELEMS_PER_LINE)
			exp_rd_opcode = READ_PNA;
		else
			exp_rd_opcode = READ_CL_NA;
	end

	// command and response bookkeeping
	always @(posedge clock) begin
		if (!rstn) begin
			rd_index     <= 0;
			pf_index     <= 0;
			rd_elem_sum  <= 0;
			rd_out_count <= 0;
			pf_out_count <= 0;
			rd_queue.delete();
			pf_queue.delete();
		end else begin
			rd_out_count <= rd_out_count + int'(read_cmd_valid) - int'(read_resp_valid);
			pf_out_count <= pf_out_count + int'(prefetch_cmd_valid) - int'(prefetch_resp_valid);
			if (read_cmd_valid) begin
				rd_index    <= rd_index + 1;
				rd_elem_sum <= rd_elem_sum + read_cmd_elems;
				rd_queue.push_back(read_cmd_elems);
			end
			if (prefetch_cmd_valid) begin
				pf_index <= pf_index + 1;
				pf_queue.push_back(1'b1);
			end
		end
	end

	// memory side, one response per class per cycle after a random gap
	always @(posedge clock) begin : responder
		logic [31:0] r;
		#1;
		r                   = $random(seed);
		read_cmd_full       = pressure && (r[1:0] == 2'd0);
		data_out_full       = pressure && (r[3:2] == 2'd0);
		prefetch_cmd_full   = pressure && (r[5:4] == 2'd0);
		read_resp_valid     = 1'b0;
		prefetch_resp_valid = 1'b0;
		if (rd_wait > 0) begin
			rd_wait--;
		end else if (rd_queue.size() > 0) begin
			read_resp_valid = 1'b1;
			read_resp_elems = rd_queue.pop_front();
			rd_wait         = r[10:8];
		end
		if (pf_wait > 0) begin
			pf_wait--;
		end else if (pf_queue.size() > 0) begin
			prefetch_resp_valid = pf_queue.pop_front();
			pf_wait             = r[13:11];
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// checks
	////////////////////////////////////////////////////////////////////////////

	a_reset_state: assert property (@(posedge clock) $rose(rstn) |->
		!read_cmd_valid && !prefetch_cmd_valid && !job_done && elements_done == '0)
		else report_error("outputs not cleared by reset");

	a_read_address: assert property (@(posedge clock) disable iff (!rstn)
		read_cmd_valid |-> read_cmd_address == exp_rd_address)
		else report_error($sformatf("read %0d address %h, expected %h",
			$sampled(rd_index), $sampled(read_cmd_address), $sampled(exp_rd_address)));

	a_read_elems: assert property (@(posedge clock) disable iff (!rstn)
		read_cmd_valid |-> exp_rd_left != '0 && read_cmd_elems == exp_rd_elems)
		else report_error($sformatf("read %0d carries %0d elements, expected %0d",
			$sampled(rd_index), $sampled(read_cmd_elems), $sampled(exp_rd_elems)));

	a_read_opcode: assert property (@(posedge clock) disable iff (!rstn)
		read_cmd_valid |-> read_cmd_opcode == exp_rd_opcode)
		else report_error($sformatf("read %0d opcode %h, expected %h", $sampled(rd_index),
			$sampled(read_cmd_opcode), $sampled(exp_rd_opcode)));

	a_command_tag: assert property (@(posedge clock) disable iff (!rstn)
		read_cmd_valid || prefetch_cmd_valid |-> command_tag == `RE_TAG)
		else report_error($sformatf("command tag %h, expected %h",
			$sampled(command_tag), `RE_TAG));

	a_burst_limit: assert property (@(posedge clock) disable iff (!rstn)
		rd_out_count <= `RE_MAX_BURST)
		else report_error($sformatf("%0d reads outstanding", $sampled(rd_out_count)));

	a_touch_address: assert property (@(posedge clock) disable iff (!rstn)
		prefetch_cmd_valid |-> prefetch_cmd_address == exp_pf_address && pf_index < exp_pf_total)
		else report_error($sformatf("touch %0d address %h, expected %h of %0d touches",
			$sampled(pf_index), $sampled(prefetch_cmd_address), $sampled(exp_pf_address),
			$sampled(exp_pf_total)));

	// touch pass completes before the first read
	a_touch_order: assert property (@(posedge clock) disable iff (!rstn)
		prefetch_cmd_valid |-> rd_index == 0)
		else report_error("touch command after a read command");

	a_touch_count: assert property (@(posedge clock) disable iff (!rstn)
		read_cmd_valid && rd_index == 0 |-> pf_index == exp_pf_total)
		else report_error($sformatf("%0d touches before the first read, expected %0d",
			$sampled(pf_index), $sampled(exp_pf_total)));

	a_read_full: assert property (@(posedge clock) disable iff (!rstn)
		read_cmd_full |=> !read_cmd_valid)
		else report_error("read command issued while the read buffer was full");

	a_data_full: assert property (@(posedge clock) disable iff (!rstn)
		data_out_full && job_cfg.gate_mode == GATE_ON_DATA_FULL |=> !read_cmd_valid)
		else report_error("read command issued while the data buffer was full");

	a_touch_full: assert property (@(posedge clock) disable iff (!rstn)
		prefetch_cmd_full |=> !prefetch_cmd_valid)
		else report_error("touch command issued while the touch buffer was full");

	// enable is registered once inside the engine
	a_enable_hold: assert property (@(posedge clock) disable iff (!rstn)
		!enable |=> ##1 !(read_cmd_valid || prefetch_cmd_valid))
		else report_error("command issued while the engine was disabled");

	a_done_drained: assert property (@(posedge clock) disable iff (!rstn)
		$rose(job_done) |-> rd_out_count == 0 && pf_out_count == 0)
		else report_error("job done with responses still outstanding");

	a_done_count: assert property (@(posedge clock) disable iff (!rstn)
		$rose(job_done) |-> elements_done == job_size && rd_elem_sum == job_size &&
			pf_index == exp_pf_total)
		else report_error($sformatf("job done with %0d elements done, %0d requested, size %0d",
			$sampled(elements_done), $sampled(rd_elem_sum), $sampled(job_size)));

	a_done_holds: assert property (@(posedge clock) disable iff (!rstn)
		job_done |=> job_done)
		else report_error("job done dropped before reset");

	////////////////////////////////////////////////////////////////////////////
	// jobs
	////////////////////////////////////////////////////////////////////////////

	task automatic define_job(input int idx, input string name, input logic [63:0] base,
		input logic [31:0] size, input logic shared, input gate_mode_t gate,
		input bit pf, input bit press, input bit pause);
		name_list[idx]              = name;
		base_list[idx]              = base;
		size_list[idx]              = size;
		cfg_list[idx].shared_reads  = shared;
		cfg_list[idx].gate_mode     = gate;
		pf_list[idx]                = pf;
		pressure_list[idx]          = press;
		pause_list[idx]             = pause;
	endtask

	function automatic int expected_commands(input int idx);
		int n;
		n = (size_list[idx] + `RE_ELEMS_PER_LINE - 1) / `RE_ELEMS_PER_LINE;
		if (pf_list[idx])
			n += (size_list[idx] + `RE_ELEMS_PER_PAGE - 1) / `RE_ELEMS_PER_PAGE;
		return n;
	endfunction

	task automatic run_job(input int idx);
		int errors_before;
		int cycles;
		errors_before = error_count;
		@(posedge clock);
		#1;
		rstn            = 1'b0;
		enable          = 1'b0;
		job_valid       = 1'b0;
		job_base        = base_list[idx];
		job_size        = size_list[idx];
		job_cfg         = cfg_list[idx];
		prefetch_enable = pf_list[idx];
		pressure        = pressure_list[idx];
		repeat (10) @(posedge clock);
		#1;
		rstn   = 1'b1;
		enable = 1'b1;
		repeat (3) @(posedge clock);
		#1;
		job_valid = 1'b1;
		cycles    = 0;
		while (!job_done) begin
			@(posedge clock);
			#1;
			cycles++;
			// engine stalls mid job
			if (pause_list[idx] && cycles == 30)
				enable = 1'b0;
			if (pause_list[idx] && cycles == 50)
				enable = 1'b1;
		end
		job_valid = 1'b0;
		repeat (2) @(posedge clock);
		#1;
		if (error_count == errors_before) begin
			$display("test %0d %s: ok after %0d cycles", idx, name_list[idx], cycles);
		end else begin
			failed_tests++;
			$display("test %0d %s: failed with %0d errors", idx, name_list[idx],
				error_count - errors_before);
		end
	endtask

	initial begin
		int limit;
		rstn                = 1'b0;
		enable              = 1'b0;
		prefetch_enable     = 1'b0;
		job_valid           = 1'b0;
		job_base            = '0;
		job_size            = '0;
		job_cfg             = '0;
		read_cmd_full       = 1'b0;
		prefetch_cmd_full   = 1'b0;
		data_out_full       = 1'b0;
		read_resp_valid     = 1'b0;
		read_resp_elems     = '0;
		prefetch_resp_valid = 1'b0;

		define_job(0, "short shared", 64'h0000_0000_1000_0000, 100, 1'b1, GATE_ALWAYS,
			0, 0, 0);
		define_job(1, "two bursts", 64'h0000_0001_0000_0080, 1000, 1'b0, GATE_ON_DATA_FULL,
			0, 1, 0);
		define_job(2, "prefetch unaligned", 64'h0000_0004_0000_1a80, 2500, 1'b1, GATE_BYPASS,
			1, 1, 1);
		define_job(3, "single line", 64'h0000_0000_0020_0f00, 32, 1'b0, GATE_ALWAYS,
			1, 0, 0);
		define_job(4, "random size", 64'h0000_00ff_ffff_e000, 1 + ($random(seed) & 'h7ff),
			1'b0, GATE_ON_DATA_FULL, 1, 1, 1);

		// reset, pause and drain cost a fixed amount per job
		limit = 500;
		for (int i = 0; i < NUM_JOBS; i++)
			limit += 20 * expected_commands(i) + 150;
		timeout_limit = limit;

		for (int i = 0; i < NUM_JOBS; i++)
			run_job(i);

		$display("%0d tests, %0d failed, %0d errors", NUM_JOBS, failed_tests, error_count);
		if (error_count == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

	initial begin
		wait (timeout_limit > 0);
		while (cycle_count < timeout_limit) begin
			@(posedge clock);
			cycle_count++;
		end
		$display("timeout: the jobs did not finish within %0d cycles", timeout_limit);
		$display("STATUS: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: all.f
+incdir+source
source/command_pkg.sv
source/control_pkg.sv
source/engine_ifs.sv
source/job_intake.sv
source/stream_sequencer.sv
source/read_command_issuer.sv
source/prefetch_command_issuer.sv
source/response_tracker.sv
source/read_engine_top.sv
sim/tb_read_engine.sv
